//--- rtl/pipePkg.sv
package pipePkg;

	typedef logic [31:0] pcT;
	typedef logic [31:0] instrT;
	typedef logic [31:0] wordT; // gpr operand or extended immediate
	typedef logic [4:0]  excCodeT;
	typedef logic [4:0]  regAddrT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;
	typedef logic [15:0] imm16T;
	typedef logic [7:0]  cp0AddrT; // {rd, sel}
	typedef logic [4:0]  aluOpT;
	typedef logic [3:0]  dmSelT; // byte lanes

	// boot vector minus one instruction
	localparam pcT FetchResetPc = 32'hbfbf_fffc;

	localparam int OpcodeMsb = 31;
	localparam int OpcodeLsb = 26;
	localparam int RsMsb     = 25;
	localparam int RsLsb     = 21;
	localparam int RtMsb     = 20;
	localparam int RtLsb     = 16;
	localparam int RdMsb     = 15;
	localparam int RdLsb     = 11;
	localparam int ShamtMsb  = 10;
	localparam int ShamtLsb  = 6;
	localparam int FunctMsb  = 5;
	localparam int FunctLsb  = 0;
	localparam int ImmMsb    = 15;
	localparam int ImmLsb    = 0;
	localparam int CpSelMsb  = 2; // mtc0/mfc0 sel field
	localparam int CpSelLsb  = 0;

endpackage

//--- rtl/fetchStageReg.sv
`timescale 1ns/100ps

module fetchStageReg (
	input  logic             clk,
	input  logic             rstN,
	input  logic             wr,
	input  logic             flush,
	input  pipePkg::pcT      fetchPc,
	input  logic             fetchException,
	input  pipePkg::excCodeT fetchExcCode,
	output pipePkg::pcT      ifPc,
	output logic             ifException,
	output pipePkg::excCodeT ifExcCode
);

	// clear lands the next sequential fetch on the boot vector
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			ifPc        <= pipePkg::FetchResetPc;
			ifException <= 1'b0;
			ifExcCode   <= '0;
		end else if (wr) begin
			ifPc        <= fetchPc;
			ifException <= fetchException; // address error on fetch
			ifExcCode   <= fetchExcCode;
		end
	end

	ifExcClearedByReset: assert property (
		@(posedge clk) !rstN |=> !ifException
	);

endmodule

//--- rtl/decodeStageReg.sv
`timescale 1ns/100ps

module decodeStageReg (
	input  logic              clk,
	input  logic              rstN,
	input  logic              wr,
	input  logic              flush,
	input  pipePkg::instrT    instr,
	input  pipePkg::pcT       ifPc,
	input  logic              ifException,
	input  pipePkg::excCodeT  ifExcCode,
	output pipePkg::pcT       idPc,
	output pipePkg::instrT    idInstr,
	output logic              idException,
	output pipePkg::excCodeT  idExcCode,
	output pipePkg::opcodeT   idOpcode,
	output pipePkg::functT    idFunct,
	output pipePkg::regAddrT  idRs,
	output pipePkg::regAddrT  idRt,
	output pipePkg::regAddrT  idRd,
	output pipePkg::regAddrT  idShamt,
	output pipePkg::imm16T    idImm16,
	output pipePkg::cp0AddrT  idCp0Addr
);

	// pc survives a flush so the epc of a squashed slot stays valid
	always_ff @(posedge clk) begin
		if (!rstN)
			idPc <= '0;
		else if (!flush && wr)
			idPc <= ifPc;
	end

	// fields split here so decode reads them straight from flops
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			idInstr     <= '0;
			idException <= 1'b0;
			idExcCode   <= '0;
			idOpcode    <= '0;
			idFunct     <= '0;
			idRs        <= '0;
			idRt        <= '0;
			idRd        <= '0;
			idShamt     <= '0;
			idImm16     <= '0;
			idCp0Addr   <= '0;
		end else if (wr) begin
			idInstr     <= instr;
			idException <= ifException;
			idExcCode   <= ifExcCode;
			idOpcode    <= instr[pipePkg::OpcodeMsb:pipePkg::OpcodeLsb];
			idFunct     <= instr[pipePkg::FunctMsb:pipePkg::FunctLsb];
			idRs        <= instr[pipePkg::RsMsb:pipePkg::RsLsb];
			idRt        <= instr[pipePkg::RtMsb:pipePkg::RtLsb];
			idRd        <= instr[pipePkg::RdMsb:pipePkg::RdLsb];
			idShamt     <= instr[pipePkg::ShamtMsb:pipePkg::ShamtLsb];
			idImm16     <= instr[pipePkg::ImmMsb:pipePkg::ImmLsb];
			idCp0Addr   <= {instr[pipePkg::RdMsb:pipePkg::RdLsb],
				instr[pipePkg::CpSelMsb:pipePkg::CpSelLsb]}; // rd then sel
		end
	end

	idExcClearedByFlush: assert property (
		@(posedge clk) flush |=> !idException
	);

endmodule

//--- rtl/executeStageReg.sv
`timescale 1ns/100ps

module executeStageReg (
	input  logic              clk,
	input  logic              rstN,
	input  logic              wr,
	input  logic              flush,
	input  pipePkg::pcT       idPc,
	input  logic              idException,
	input  pipePkg::excCodeT  idExcCode,
	input  pipePkg::regAddrT  idRs,
	input  pipePkg::regAddrT  idRt,
	input  pipePkg::regAddrT  idRd,
	input  pipePkg::regAddrT  idShamt,
	input  logic              rfWr,
	input  logic              dmWr,
	input  logic              dmRd,
	input  pipePkg::aluOpT    aluOp,
	input  pipePkg::dmSelT    dmSel,
	input  pipePkg::wordT     gprRs,
	input  pipePkg::wordT     gprRt,
	input  pipePkg::wordT     imm32,
	output pipePkg::pcT       exPc,
	output logic              exException,
	output pipePkg::excCodeT  exExcCode,
	output pipePkg::regAddrT  exRs,
	output pipePkg::regAddrT  exRt,
	output pipePkg::regAddrT  exRd,
	output pipePkg::regAddrT  exShamt,
	output logic              exRfWr,
	output logic              exDmWr,
	output logic              exDmRd,
	output pipePkg::aluOpT    exAluOp,
	output pipePkg::dmSelT    exDmSel,
	output pipePkg::wordT     exGprRs,
	output pipePkg::wordT     exGprRt,
	output pipePkg::wordT     exImm32,
	output logic              exStall
);

	always_ff @(posedge clk) begin
		if (!rstN)
			exPc <= '0;
		else if (!flush && wr)
			exPc <= idPc; // kept across flush
	end

	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			exException <= 1'b0;
			exExcCode   <= '0;
			exRs        <= '0;
			exRt        <= '0;
			exRd        <= '0;
			exShamt     <= '0;
			exRfWr      <= 1'b0;
			exDmWr      <= 1'b0;
			exDmRd      <= 1'b0;
			exAluOp     <= '0;
			exDmSel     <= '0;
			exGprRs     <= '0;
			exGprRt     <= '0;
			exImm32     <= '0;
			exStall     <= 1'b0;
		end else if (wr) begin
			exException <= idException;
			exExcCode   <= idExcCode;
			exRs        <= idRs;
			exRt        <= idRt;
			exRd        <= idRd;
			exShamt     <= idShamt;
			exRfWr      <= rfWr;
			exDmWr      <= dmWr;
			exDmRd      <= dmRd;
			exAluOp     <= aluOp;
			exDmSel     <= dmSel;
			exGprRs     <= gprRs;
			exGprRt     <= gprRt;
			exImm32     <= imm32;
			exStall     <= 1'b0;
		end else begin
			exStall <= 1'b1; // holding the previous op
		end
	end

	exDmExclusive: assert property (
		@(posedge clk) disable iff (!rstN) !(exDmWr && exDmRd)
	);

endmodule

//--- rtl/frontPipe.sv
`timescale 1ns/100ps

module frontPipe (
	input  logic              clk,
	input  logic              rstN,
	input  logic              fetchWr,
	input  logic              fetchFlush,
	input  logic              decodeWr,
	input  logic              decodeFlush,
	input  logic              executeWr,
	input  logic              executeFlush,
	input  pipePkg::pcT       fetchPc,
	input  logic              fetchException,
	input  pipePkg::excCodeT  fetchExcCode,
	input  pipePkg::instrT    instr,
	input  logic              rfWr,
	input  logic              dmWr,
	input  logic              dmRd,
	input  pipePkg::aluOpT    aluOp,
	input  pipePkg::dmSelT    dmSel,
	input  pipePkg::wordT     gprRs,
	input  pipePkg::wordT     gprRt,
	input  pipePkg::wordT     imm32,
	output pipePkg::pcT       ifPc,
	output logic              ifException,
	output pipePkg::excCodeT  ifExcCode,
	output pipePkg::pcT       idPc,
	output pipePkg::instrT    idInstr,
	output logic              idException,
	output pipePkg::excCodeT  idExcCode,
	output pipePkg::opcodeT   idOpcode,
	output pipePkg::functT    idFunct,
	output pipePkg::regAddrT  idRs,
	output pipePkg::regAddrT  idRt,
	output pipePkg::regAddrT  idRd,
	output pipePkg::regAddrT  idShamt,
	output pipePkg::imm16T    idImm16,
	output pipePkg::cp0AddrT  idCp0Addr,
	output pipePkg::pcT       exPc,
	output logic              exException,
	output pipePkg::excCodeT  exExcCode,
	output pipePkg::regAddrT  exRs,
	output pipePkg::regAddrT  exRt,
	output pipePkg::regAddrT  exRd,
	output pipePkg::regAddrT  exShamt,
	output logic              exRfWr,
	output logic              exDmWr,
	output logic              exDmRd,
	output pipePkg::aluOpT    exAluOp,
	output pipePkg::dmSelT    exDmSel,
	output pipePkg::wordT     exGprRs,
	output pipePkg::wordT     exGprRt,
	output pipePkg::wordT     exImm32,
	output logic              exStall
);

	fetchStageReg i_fetch (
		.clk, .rstN, .wr(fetchWr), .flush(fetchFlush),
		.fetchPc, .fetchException, .fetchExcCode,
		.ifPc, .ifException, .ifExcCode
	);

	decodeStageReg i_decode (
		.clk, .rstN, .wr(decodeWr), .flush(decodeFlush),
		.instr, .ifPc, .ifException, .ifExcCode,
		.idPc, .idInstr, .idException, .idExcCode,
		.idOpcode, .idFunct, .idRs, .idRt, .idRd, .idShamt,
		.idImm16, .idCp0Addr
	);

	// controls and operands come from the decoder outside this block
	executeStageReg i_execute (
		.clk, .rstN, .wr(executeWr), .flush(executeFlush),
		.idPc, .idException, .idExcCode,
		.idRs, .idRt, .idRd, .idShamt,
		.rfWr, .dmWr, .dmRd, .aluOp, .dmSel,
		.gprRs, .gprRt, .imm32,
		.exPc, .exException, .exExcCode,
		.exRs, .exRt, .exRd, .exShamt,
		.exRfWr, .exDmWr, .exDmRd, .exAluOp, .exDmSel,
		.exGprRs, .exGprRt, .exImm32, .exStall
	);

endmodule

//--- verification/frontPipeTb.sv
`timescale 1ns/100ps

module frontPipeTb;

	localparam time ClkPeriod    = 20ns;
	localparam int  ResetCycles  = 10;
	localparam int  StreamCycles = 40;
	localparam int  HoldCycles   = 4;
	localparam int  FlushCycles  = 8;
	localparam int  RandomCycles = 400;
	localparam int  TotalCycles  = ResetCycles + StreamCycles + HoldCycles + 1
		+ FlushCycles + RandomCycles + 4;

	typedef struct packed {
		logic              fetchWr;
		logic              fetchFlush;
		logic              decodeWr;
		logic              decodeFlush;
		logic              executeWr;
		logic              executeFlush;
		pipePkg::pcT       fetchPc;
		logic              fetchException;
		pipePkg::excCodeT  fetchExcCode;
		pipePkg::instrT    instr;
		logic              rfWr;
		logic              dmWr;
		logic              dmRd;
		pipePkg::aluOpT    aluOp;
		pipePkg::dmSelT    dmSel;
		pipePkg::wordT     gprRs;
		pipePkg::wordT     gprRt;
		pipePkg::wordT     imm32;
	} stimT;

	// ex fields cleared by a flush except the stall marker
	typedef struct packed {
		logic              exception;
		pipePkg::excCodeT  excCode;
		pipePkg::regAddrT  rs;
		pipePkg::regAddrT  rt;
		pipePkg::regAddrT  rd;
		pipePkg::regAddrT  shamt;
		logic              rfWr;
		logic              dmWr;
		logic              dmRd;
		pipePkg::aluOpT    aluOp;
		pipePkg::dmSelT    dmSel;
		pipePkg::wordT     gprRs;
		pipePkg::wordT     gprRt;
		pipePkg::wordT     imm32;
	} exCtlT;

	typedef struct packed {
		pipePkg::pcT       ifPc;
		logic              ifException;
		pipePkg::excCodeT  ifExcCode;
		pipePkg::pcT       idPc;
		pipePkg::instrT    idInstr; // id fields are derived from this
		logic              idException;
		pipePkg::excCodeT  idExcCode;
		pipePkg::pcT       exPc;
		exCtlT             ex;
		logic              exStall;
	} modelT;

	logic  clk;
	logic  rstN;
	stimT  stim;
	modelT expState;
	int    errorCount = 0;
	int    checkCount = 0;

	pipePkg::pcT      ifPc, idPc, exPc;
	logic             ifException, idException, exException;
	pipePkg::excCodeT ifExcCode, idExcCode, exExcCode;
	pipePkg::instrT   idInstr;
	pipePkg::opcodeT  idOpcode;
	pipePkg::functT   idFunct;
	pipePkg::regAddrT idRs, idRt, idRd, idShamt, exRs, exRt, exRd, exShamt;
	pipePkg::imm16T   idImm16;
	pipePkg::cp0AddrT idCp0Addr;
	logic             exRfWr, exDmWr, exDmRd, exStall;
	pipePkg::aluOpT   exAluOp;
	pipePkg::dmSelT   exDmSel;
	pipePkg::wordT    exGprRs, exGprRt, exImm32;

	frontPipe i_dut (
		.clk, .rstN,
		.fetchWr(stim.fetchWr), .fetchFlush(stim.fetchFlush),
		.decodeWr(stim.decodeWr), .decodeFlush(stim.decodeFlush),
		.executeWr(stim.executeWr), .executeFlush(stim.executeFlush),
		.fetchPc(stim.fetchPc), .fetchException(stim.fetchException),
		.fetchExcCode(stim.fetchExcCode), .instr(stim.instr),
		.rfWr(stim.rfWr), .dmWr(stim.dmWr), .dmRd(stim.dmRd),
		.aluOp(stim.aluOp), .dmSel(stim.dmSel),
		.gprRs(stim.gprRs), .gprRt(stim.gprRt), .imm32(stim.imm32),
		.ifPc, .ifException, .ifExcCode,
		.idPc, .idInstr, .idException, .idExcCode,
		.idOpcode, .idFunct, .idRs, .idRt, .idRd, .idShamt, .idImm16, .idCp0Addr,
		.exPc, .exException, .exExcCode, .exRs, .exRt, .exRd, .exShamt,
		.exRfWr, .exDmWr, .exDmRd, .exAluOp, .exDmSel,
		.exGprRs, .exGprRt, .exImm32, .exStall
	);

	// expected state after one clock edge
	function automatic modelT nextState(modelT cur, stimT s, logic rst);
		modelT n;
		n = cur;
		if (!rst || s.fetchFlush) begin
			n.ifPc        = pipePkg::FetchResetPc;
			n.ifException = 1'b0;
			n.ifExcCode   = '0;
		end else if (s.fetchWr) begin
			n.ifPc        = s.fetchPc;
			n.ifException = s.fetchException;
			n.ifExcCode   = s.fetchExcCode;
		end
		if (!rst)
			n.idPc = '0;
		else if (!s.decodeFlush && s.decodeWr)
			n.idPc = cur.ifPc; // flush keeps it
		if (!rst || s.decodeFlush) begin
			n.idInstr     = '0;
			n.idException = 1'b0;
			n.idExcCode   = '0;
		end else if (s.decodeWr) begin
			n.idInstr     = s.instr;
			n.idException = cur.ifException;
			n.idExcCode   = cur.ifExcCode;
		end
		if (!rst)
			n.exPc = '0;
		else if (!s.executeFlush && s.executeWr)
			n.exPc = cur.idPc;
		if (!rst || s.executeFlush) begin
			n.ex      = '0;
			n.exStall = 1'b0;
		end else if (s.executeWr) begin
			n.ex = {cur.idException, cur.idExcCode,
				cur.idInstr[pipePkg::RsMsb:pipePkg::RsLsb],
				cur.idInstr[pipePkg::RtMsb:pipePkg::RtLsb],
				cur.idInstr[pipePkg::RdMsb:pipePkg::RdLsb],
				cur.idInstr[pipePkg::ShamtMsb:pipePkg::ShamtLsb],
				s.rfWr, s.dmWr, s.dmRd, s.aluOp, s.dmSel, s.gprRs, s.gprRt, s.imm32};
			n.exStall = 1'b0;
		end else begin
			n.exStall = 1'b1; // held this edge
		end
		return n;
	endfunction

	function automatic stimT randomStim(int wrPct, int flushPct);
		stimT s;
		int dmCode;
		s.fetchWr        = $urandom_range(99) < wrPct;
		s.fetchFlush     = $urandom_range(99) < flushPct;
		s.decodeWr       = $urandom_range(99) < wrPct;
		s.decodeFlush    = $urandom_range(99) < flushPct;
		s.executeWr      = $urandom_range(99) < wrPct;
		s.executeFlush   = $urandom_range(99) < flushPct;
		s.fetchPc        = $urandom;
		s.fetchException = $urandom_range(99) < 25;
		s.fetchExcCode   = $urandom_range(31);
		s.instr          = $urandom;
		s.rfWr           = $urandom_range(1);
		dmCode           = $urandom_range(2); // load and store are exclusive
		s.dmWr           = (dmCode == 1);
		s.dmRd           = (dmCode == 2);
		s.aluOp          = $urandom_range(31);
		s.dmSel          = $urandom_range(15);
		s.gprRs          = $urandom;
		s.gprRt          = $urandom;
		s.imm32          = $urandom;
		return s;
	endfunction

	task automatic check(string name, logic [31:0] got, logic [31:0] want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic checkOutputs(modelT m);
		check("ifPc", ifPc, m.ifPc);
		check("ifException", ifException, m.ifException);
		check("ifExcCode", ifExcCode, m.ifExcCode);
		check("idPc", idPc, m.idPc);
		check("idInstr", idInstr, m.idInstr);
		check("idException", idException, m.idException);
		check("idExcCode", idExcCode, m.idExcCode);
		check("idOpcode", idOpcode, m.idInstr[pipePkg::OpcodeMsb:pipePkg::OpcodeLsb]);
		check("idFunct", idFunct, m.idInstr[pipePkg::FunctMsb:pipePkg::FunctLsb]);
		check("idRs", idRs, m.idInstr[pipePkg::RsMsb:pipePkg::RsLsb]);
		check("idRt", idRt, m.idInstr[pipePkg::RtMsb:pipePkg::RtLsb]);
		check("idRd", idRd, m.idInstr[pipePkg::RdMsb:pipePkg::RdLsb]);
		check("idShamt", idShamt, m.idInstr[pipePkg::ShamtMsb:pipePkg::ShamtLsb]);
		check("idImm16", idImm16, m.idInstr[pipePkg::ImmMsb:pipePkg::ImmLsb]);
		check("idCp0Addr", idCp0Addr, {m.idInstr[pipePkg::RdMsb:pipePkg::RdLsb],
			m.idInstr[pipePkg::CpSelMsb:pipePkg::CpSelLsb]});
		check("exPc", exPc, m.exPc);
		check("exException", exException, m.ex.exception);
		check("exExcCode", exExcCode, m.ex.excCode);
		check("exRs", exRs, m.ex.rs);
		check("exRt", exRt, m.ex.rt);
		check("exRd", exRd, m.ex.rd);
		check("exShamt", exShamt, m.ex.shamt);
		check("exRfWr", exRfWr, m.ex.rfWr);
		check("exDmWr", exDmWr, m.ex.dmWr);
		check("exDmRd", exDmRd, m.ex.dmRd);
		check("exAluOp", exAluOp, m.ex.aluOp);
		check("exDmSel", exDmSel, m.ex.dmSel);
		check("exGprRs", exGprRs, m.ex.gprRs);
		check("exGprRt", exGprRt, m.ex.gprRt);
		check("exImm32", exImm32, m.ex.imm32);
		check("exStall", exStall, m.exStall);
	endtask

	task automatic applyStim(stimT s);
		@(posedge clk);
		stim <= s;
	endtask

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// model steps on the edge, outputs are compared half a cycle later
	initial begin
		forever begin
			@(posedge clk);
			expState = nextState(expState, stim, rstN);
			@(negedge clk);
			checkOutputs(expState);
		end
	end

	initial begin
		stimT s;
		void'($urandom(96720));
		rstN = 1'b0;
		stim = '0;
		repeat (ResetCycles) @(posedge clk);
		rstN <= 1'b1;
		repeat (StreamCycles) applyStim(randomStim(100, 0)); // all stages open
		s = randomStim(100, 0);
		s.executeWr = 1'b0;
		repeat (HoldCycles) applyStim(s); // ex holds, stall marker rises
		applyStim(randomStim(100, 0));
		repeat (FlushCycles) applyStim(randomStim(100, 50));
		repeat (RandomCycles) applyStim(randomStim(75, 10));
		repeat (2) @(posedge clk);
		@(negedge clk);
		#1;
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		#(TotalCycles * ClkPeriod + 10 * ClkPeriod);
		$display("Timeout: the test did not finish in the expected number of cycles");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- compile.f
rtl/pipePkg.sv
rtl/fetchStageReg.sv
rtl/decodeStageReg.sv
rtl/executeStageReg.sv
rtl/frontPipe.sv
verification/frontPipeTb.sv

//--- Bender.yml
package:
  name: front_pipe

sources:
  - rtl/pipePkg.sv
  - rtl/fetchStageReg.sv
  - rtl/decodeStageReg.sv
  - rtl/executeStageReg.sv
  - rtl/frontPipe.sv
  - target: test
    files:
      - verification/frontPipeTb.sv
